//--- source/vis_pkg.sv
package vis_pkg;

  localparam int DATA_W   = 16;              // processor word width
  localparam int NUM_REGS = 16;              // r0 .. r15
  localparam int FLAG_W   = 5;               // s, z, o, c, cb from bit 0 up
  localparam int CHAR_W   = 8;               // one ascii byte

  localparam logic [DATA_W-1:0] HALT_CODE = 16'h0000;  // halt opcode, all zeros

  localparam int NUM_WORD_LINES = NUM_REGS + 1;        // registers plus pc
  localparam int NUM_LINES      = NUM_WORD_LINES + FLAG_W;  // 22 lines per dump

  localparam logic [CHAR_W-1:0] LINE_END_LF = 8'h0A;   // line feed goes first
  localparam logic [CHAR_W-1:0] LINE_END_CR = 8'h0D;   // then carriage return

  typedef logic [DATA_W-1:0] word_t;
  typedef logic [CHAR_W-1:0] char_t;

  // full processor state, 277 bits
  typedef struct packed {
    word_t [NUM_REGS-1:0] regs;                // general registers
    word_t                pc;                  // program counter
    logic  [FLAG_W-1:0]   flags;               // sign at bit 0
  } cpu_state_t;

  // four-character label of every dump line, first char in the top byte
  localparam logic [4*CHAR_W-1:0] LINE_LABEL [NUM_LINES] = '{
    "R0= ",
    "R1= ",
    "R2= ",
    "R3= ",
    "R4= ",
    "R5= ",
    "R6= ",
    "R7= ",
    "R8= ",
    "R9= ",
    "R10=",
    "R11=",
    "R12=",
    "R13=",
    "R14=",
    "R15=",
    "PC= ",
    "S = ",
    "Z = ",
    "O = ",
    "C = ",
    "CB= "
  };

endpackage

//--- source/halt_snapshot.sv
`timescale 1ns/100ps

module halt_snapshot (
  input  logic                clk_,
  input  logic                rst,
  input  vis_pkg::word_t      instr,       // instruction word under watch
  input  vis_pkg::cpu_state_t cpu_state,   // live processor state
  input  logic                fmt_busy,    // formatter still emitting
  input  logic                fifo_empty,  // text buffer drained
  input  logic                tx_idle,     // uart line quiet
  output vis_pkg::cpu_state_t snap,        // frozen state for the dump
  output logic                dump_start,  // one-cycle kick to formatter
  output logic                dump_busy    // high for the whole dump
);
  import vis_pkg::*;

  logic halt_now;                          // instr is halt this cycle
  logic prev_halt;                         // instr was halt last cycle
  logic trigger;                           // edge into halt, unit free
  logic drained;                           // whole chain has gone quiet

  assign halt_now = (instr == HALT_CODE);
  assign trigger  = halt_now && !prev_halt && !dump_busy;  // held halt counts once
  assign drained  = !fmt_busy && fifo_empty && tx_idle;

  // previous-instruction tracker
  always_ff @(posedge clk_ or negedge rst)
  begin
    if (!rst)
      prev_halt <= 1'b0;
    else
      prev_halt <= halt_now;
  end

  // capture register, only loaded on a qualifying halt
  always_ff @(posedge clk_)
  begin
    if (trigger)
      snap <= cpu_state;                   // stays put until the next dump
  end

  // start pulse and busy level
  always_ff @(posedge clk_ or negedge rst)
  begin
    if (!rst)
    begin
      dump_start <= 1'b0;
      dump_busy  <= 1'b0;
    end
    else
    begin
      dump_start <= trigger;               // single cycle, trigger needs !busy
      if (trigger)
        dump_busy <= 1'b1;
      else if (dump_busy && drained)
        dump_busy <= 1'b0;                 // fmt_busy covers the start cycle
    end
  end

endmodule

//--- source/dump_formatter.sv
`timescale 1ns/100ps

module dump_formatter (
  input  logic                clk_,
  input  logic                rst,
  input  vis_pkg::cpu_state_t snap,        // captured state, steady during dump
  input  logic                dump_start,  // pulse from the halt detector
  input  logic                full,        // fifo back-pressure
  output vis_pkg::char_t      wr_data,     // next text byte
  output logic                wr_en,       // byte strobe into the fifo
  output logic                fmt_busy     // still walking the lines
);
  import vis_pkg::*;

  localparam int LINE_W = $clog2(NUM_LINES);
  localparam int POS_W  = 4;
  localparam logic [POS_W-1:0] LABEL_LEN = 4'd4;   // label occupies pos 0..3
  localparam logic [POS_W-1:0] HEX_LAST  = 4'd9;   // label, 4 digits, lf, cr
  localparam logic [POS_W-1:0] FLAG_LAST = 4'd6;   // label, 1 digit, lf, cr

  logic                active;           // dump in progress
  logic [LINE_W-1:0]   line;             // current line 0..21
  logic [POS_W-1:0]    pos;              // byte within the line
  logic                flag_line;        // lines 17..21 carry one flag
  logic [POS_W-1:0]    last_pos;         // position of the cr byte
  logic                line_done;        // cr being written
  logic                dump_done;        // final cr of the dump
  word_t               value;            // register or pc for this line
  logic [4*CHAR_W-1:0] label;            // label text of this line
  logic [1:0]          hex_sel;          // which digit, msd first
  logic [3:0]          nibble;           // digit value
  logic [2:0]          flag_sel;         // flag index, sign first
  char_t               label_char;
  char_t               hex_out;
  char_t               flag_char;

  // nibble to upper-case ascii hex
  function automatic char_t hex_char(input logic [3:0] nib);
    char_t base;
    if (nib < 4'd10)
      base = 8'h30;                      // '0'
    else
      base = 8'h37;                      // 'A' minus ten
    return base + {4'h0, nib};
  endfunction

  assign flag_line = (line >= LINE_W'(NUM_WORD_LINES));
  assign last_pos  = flag_line ? FLAG_LAST : HEX_LAST;
  assign line_done = (pos == last_pos);
  assign dump_done = line_done && (line == LINE_W'(NUM_LINES - 1));

  // value and label selection
  assign value    = (line < LINE_W'(NUM_REGS)) ? snap.regs[line[3:0]] : snap.pc;
  assign label    = LINE_LABEL[line];
  assign flag_sel = 3'(line - LINE_W'(NUM_WORD_LINES));
  assign hex_sel  = 2'(pos - LABEL_LEN);

  assign label_char = label[CHAR_W*(3 - pos[1:0]) +: CHAR_W];   // first char on top
  assign nibble     = value[4*(3 - hex_sel) +: 4];
  assign hex_out    = hex_char(nibble);
  assign flag_char  = {7'h18, snap.flags[flag_sel]};            // '0' or '1'

  // byte mux
  always_comb
  begin
    if (line_done)
      wr_data = LINE_END_CR;             // cr closes every line
    else if (pos == last_pos - 1'b1)
      wr_data = LINE_END_LF;
    else if (pos < LABEL_LEN)
      wr_data = label_char;
    else if (flag_line)
      wr_data = flag_char;               // no leading nul byte
    else
      wr_data = hex_out;
  end

  assign wr_en    = active && !full;     // one byte per free cycle
  assign fmt_busy = active || dump_start;

  // line and position counters
  always_ff @(posedge clk_ or negedge rst)
  begin
    if (!rst)
    begin
      active <= 1'b0;
      line   <= '0;
      pos    <= '0;
    end
    else if (dump_start)
    begin
      active <= 1'b1;                    // first byte in the next cycle
      line   <= '0;
      pos    <= '0;
    end
    else if (wr_en)
    begin
      if (line_done)
      begin
        pos  <= '0;
        line <= line + 1'b1;             // flag lines jump here from pos 6
      end
      else
        pos <= pos + 1'b1;
      if (dump_done)
        active <= 1'b0;                  // 205th byte just went out
    end
  end

endmodule

//--- source/byte_fifo.sv
`timescale 1ns/100ps

module byte_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic           clk_,
  input  logic           rst,
  input  vis_pkg::char_t wr_data,      // byte from the formatter
  input  logic           wr_en,
  input  logic           rd_en,        // pop, data taken same cycle
  output vis_pkg::char_t rd_data,      // head of queue, fall-through
  output logic           full,
  output logic           empty
);
  import vis_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  char_t            mem [FIFO_DEPTH];  // storage, no reset needed
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;             // occupancy
  logic             do_wr;
  logic             do_rd;

  assign do_wr   = wr_en && !full;
  assign do_rd   = rd_en && !empty;
  assign full    = (count == CNT_W'(FIFO_DEPTH));
  assign empty   = (count == '0);
  assign rd_data = mem[rd_ptr];        // visible one cycle after its write

  always_ff @(posedge clk_)
  begin
    if (do_wr)
      mem[wr_ptr] <= wr_data;
  end

  // pointers wrap at depth, not at a power of two
  always_ff @(posedge clk_ or negedge rst)
  begin
    if (!rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;         // both or neither
      endcase
    end
  end

endmodule

//--- source/uart_tx.sv
`timescale 1ns/100ps

module uart_tx #(
  parameter int CLKS_PER_BIT = 20000
) (
  input  logic           clk_,
  input  logic           rst,
  input  vis_pkg::char_t rd_data,      // fifo head
  input  logic           empty,        // nothing to send
  output logic           rd_en,        // pop and start a frame
  output logic           tx,           // serial line, idles high
  output logic           tx_idle       // no frame on the line
);
  import vis_pkg::*;

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

  logic              busy;             // frame in flight
  logic [CNT_W-1:0]  clk_cnt;          // clocks within current bit
  logic [3:0]        bit_cnt;          // 0 start, 1..8 data, 9 stop
  logic [CHAR_W:0]   shift_q;          // data lsb first, then stop
  logic              bit_end;          // last clock of a bit
  logic              frame_end;        // last clock of the stop bit
  logic              ready;

  assign bit_end   = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));
  assign frame_end = busy && bit_end && (bit_cnt == 4'd9);
  assign ready     = !busy || frame_end;   // next frame right after stop
  assign rd_en     = ready && !empty;
  assign tx_idle   = !busy;

  // payload shifter
  always_ff @(posedge clk_)
  begin
    if (rd_en)
      shift_q <= {1'b1, rd_data};          // stop bit sits above the data
    else if (busy && bit_end)
      shift_q <= {1'b1, shift_q[CHAR_W:1]};
  end

  // bit timing and line driver
  always_ff @(posedge clk_ or negedge rst)
  begin
    if (!rst)
    begin
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
      tx      <= 1'b1;
    end
    else if (rd_en)
    begin
      busy    <= 1'b1;
      clk_cnt <= '0;
      bit_cnt <= '0;
      tx      <= 1'b0;                     // start bit in the next cycle
    end
    else if (busy)
    begin
      if (bit_end)
      begin
        clk_cnt <= '0;
        if (bit_cnt == 4'd9)
        begin
          busy <= 1'b0;                    // stop bit done, line stays high
          tx   <= 1'b1;
        end
        else
        begin
          bit_cnt <= bit_cnt + 1'b1;
          tx      <= shift_q[0];           // data lsb first, stop last
        end
      end
      else
        clk_cnt <= clk_cnt + 1'b1;
    end
  end

endmodule

//--- source/vis_dev.sv
`timescale 1ns/100ps

module vis_dev #(
  parameter int CLKS_PER_BIT = 20000,      // clocks per uart bit
  parameter int FIFO_DEPTH   = 8           // text buffer bytes
) (
  input  logic                clk_,
  input  logic                rst,
  input  vis_pkg::word_t      instr,       // instruction word, every clock
  input  vis_pkg::cpu_state_t cpu_state,   // registers, pc and flags
  output logic                tx,          // uart transmit line
  output logic                dump_busy    // high while a dump runs
);
  import vis_pkg::*;

  cpu_state_t snap;                        // frozen state
  logic       dump_start;
  logic       fmt_busy;
  char_t      wr_data;                     // formatter to fifo
  logic       wr_en;
  logic       full;
  char_t      rd_data;                     // fifo to uart
  logic       rd_en;
  logic       empty;
  logic       tx_idle;

  halt_snapshot u_halt_snapshot (
    .clk_       (clk_),
    .rst        (rst),
    .instr      (instr),
    .cpu_state  (cpu_state),
    .fmt_busy   (fmt_busy),
    .fifo_empty (empty),
    .tx_idle    (tx_idle),
    .snap       (snap),
    .dump_start (dump_start),
    .dump_busy  (dump_busy)
  );

  dump_formatter u_dump_formatter (
    .clk_       (clk_),
    .rst        (rst),
    .snap       (snap),
    .dump_start (dump_start),
    .full       (full),
    .wr_data    (wr_data),
    .wr_en      (wr_en),
    .fmt_busy   (fmt_busy)
  );

  byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_byte_fifo (
    .clk_    (clk_),
    .rst     (rst),
    .wr_data (wr_data),
    .wr_en   (wr_en),
    .rd_en   (rd_en),
    .rd_data (rd_data),
    .full    (full),
    .empty   (empty)
  );

  uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
    .clk_    (clk_),
    .rst     (rst),
    .rd_data (rd_data),
    .empty   (empty),
    .rd_en   (rd_en),
    .tx      (tx),
    .tx_idle (tx_idle)
  );

endmodule

//--- test/vis_monitor.sv
`timescale 1ns/100ps

module vis_monitor #(
  parameter int CLKS_PER_BIT = 4
) (
  input  logic                clk_,
  input  logic                rst,
  input  vis_pkg::word_t      instr,
  input  vis_pkg::cpu_state_t cpu_state,
  input  logic                tx,
  input  logic                dump_busy,
  output int                  value_errs,       // wrong text bytes
  output int                  proto_errs,       // framing and busy faults
  output int                  dumps_started,
  output int                  dumps_done
);
  import vis_pkg::*;

  localparam int MID_BIT  = CLKS_PER_BIT / 2;   // negedges from start seen to mid-bit
  localparam int END_WAIT = CLKS_PER_BIT - MID_BIT + 2;  // last stop sample to busy low

  logic [7:0] exp_q [$];                        // expected text, oldest first
  logic [7:0] rx_byte;
  logic       rx_active;                        // inside a frame
  int         rx_phase;                         // negedges since start seen
  int         rx_total;                         // bytes decoded so far
  int         rx_base;                          // rx_total when the dump began
  logic       prev_halt;
  logic       model_busy;                       // a dump should be running
  int         end_wait;                         // negedges until busy should drop
  logic       busy_mismatch;                    // dump_busy already off the model

  initial
  begin
    value_errs    = 0;
    proto_errs    = 0;
    dumps_started = 0;
    dumps_done    = 0;
    rx_total      = 0;
    rx_base       = 0;
    end_wait      = 0;
    busy_mismatch = 1'b0;
  end

  task automatic proto_fault(input string msg);
    proto_errs++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  function automatic string line_label(input int line);
    string s;
    if (line < 10)
      s = $sformatf("R%0d= ", line);
    else if (line < NUM_REGS)
      s = $sformatf("R%0d=", line);
    else
      case (line)
        16:      s = "PC= ";
        17:      s = "S = ";
        18:      s = "Z = ";
        19:      s = "O = ";
        20:      s = "C = ";
        default: s = "CB= ";
      endcase
    return s;
  endfunction

  // reference text of one dump
  task automatic build_dump(input cpu_state_t st);
    string hex;
    string lbl;
    word_t w;
    hex = "0123456789ABCDEF";
    for (int line = 0; line < NUM_LINES; line++)
    begin
      lbl = line_label(line);
      for (int i = 0; i < 4; i++)
        exp_q.push_back(lbl[i]);
      if (line <= NUM_REGS)
      begin
        w = (line < NUM_REGS) ? st.regs[line] : st.pc;
        for (int d = 3; d >= 0; d--)
          exp_q.push_back(hex[w[4*d +: 4]]);    // top nibble first
      end
      else
        exp_q.push_back(st.flags[line - NUM_REGS - 1] ? 8'h31 : 8'h30);
      exp_q.push_back(8'h0A);                   // lf, then cr
      exp_q.push_back(8'h0D);
    end
  endtask

  task automatic byte_done();
    logic [7:0] want;
    if (exp_q.size() == 0)
      proto_fault($sformatf("byte 8'h%02h sent with no dump text pending", rx_byte));
    else
    begin
      want = exp_q.pop_front();
      if (rx_byte !== want)
      begin
        value_errs++;
        $display("[FAIL] %0t ns: dump %0d byte %0d is 8'h%02h, expected 8'h%02h",
                 $time, dumps_started, rx_total - rx_base, rx_byte, want);
      end
      if (exp_q.size() == 0)
        end_wait = END_WAIT;                    // busy drops once the stop bit ends
    end
    rx_total++;
  endtask

  // uart decode, sampled mid-bit
  task automatic sample_line();
    int k;
    if (!rx_active)
    begin
      if (tx === 1'b0)
      begin
        rx_active = 1'b1;
        rx_phase  = 0;
        if (!model_busy)
          proto_fault("tx went low with no dump running");
      end
    end
    else
    begin
      rx_phase++;
      if (rx_phase >= MID_BIT && (rx_phase - MID_BIT) % CLKS_PER_BIT == 0)
      begin
        k = (rx_phase - MID_BIT) / CLKS_PER_BIT;    // 0 start, 1..8 data, 9 stop
        if (k == 0 && tx !== 1'b0)
          proto_fault("start bit not low at mid-bit");
        else if (k >= 1 && k <= 8)
          rx_byte[k-1] = tx;                        // lsb first
        else if (k == 9)
        begin
          if (tx !== 1'b1)
            proto_fault("stop bit not high");
          byte_done();
          rx_active = 1'b0;
        end
      end
    end
  endtask

  // busy level against the model, one report per divergence
  task automatic check_busy();
    if (end_wait > 0)
    begin
      end_wait--;
      if (end_wait == 0)
      begin
        model_busy = 1'b0;                      // last frame fully on the line
        dumps_done++;
      end
    end
    if (dump_busy !== model_busy && !busy_mismatch)
      proto_fault($sformatf("dump_busy is %b, expected %b", dump_busy, model_busy));
    busy_mismatch = (dump_busy !== model_busy);
  endtask

  // halt edge while idle starts a dump on the next rising edge
  task automatic track_halt();
    logic halt_now;
    halt_now = (instr == HALT_CODE);
    if (halt_now && !prev_halt && !model_busy)
    begin
      build_dump(cpu_state);
      rx_base    = rx_total;
      model_busy = 1'b1;
      dumps_started++;
    end
    prev_halt = halt_now;
  endtask

  // negedge sees inputs and outputs settled between rising edges
  always @(negedge clk_)
  begin
    if (!rst)
    begin
      if (dump_busy !== 1'b0 || tx !== 1'b1)
        proto_fault("dump_busy or tx not idle during reset");
      prev_halt     = 1'b0;
      model_busy    = 1'b0;
      end_wait      = 0;
      busy_mismatch = 1'b0;
      rx_active     = 1'b0;
    end
    else
    begin
      sample_line();
      check_busy();
      track_halt();
    end
  end

endmodule

//--- test/tb_vis_dev.sv
`timescale 1ns/100ps

module tb_vis_dev;
  import vis_pkg::*;

  localparam int CLKS_PER_BIT = 4;                  // short bit time for simulation
  localparam int FIFO_DEPTH   = 8;
  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 10;                 // inputs change after the edge
  localparam int NUM_DUMPS    = 4;
  localparam int DUMP_BYTES   = 205;
  localparam int WATCHDOG_CYCLES = NUM_DUMPS * DUMP_BYTES * 10 * CLKS_PER_BIT + 2000;

  logic        clk_;
  logic        rst;
  word_t       instr;
  cpu_state_t  cpu_state;
  logic        tx;
  logic        dump_busy;
  int          value_errs;
  int          proto_errs;
  int          dumps_started;
  int          dumps_done;

  always #(CLK_PERIOD / 2) clk_ = ~clk_;

  vis_dev #(.CLKS_PER_BIT(CLKS_PER_BIT), .FIFO_DEPTH(FIFO_DEPTH)) u_vis_dev (
    .clk_      (clk_),
    .rst       (rst),
    .instr     (instr),
    .cpu_state (cpu_state),
    .tx        (tx),
    .dump_busy (dump_busy)
  );

  vis_monitor #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_vis_monitor (
    .clk_          (clk_),
    .rst           (rst),
    .instr         (instr),
    .cpu_state     (cpu_state),
    .tx            (tx),
    .dump_busy     (dump_busy),
    .value_errs    (value_errs),
    .proto_errs    (proto_errs),
    .dumps_started (dumps_started),
    .dumps_done    (dumps_done)
  );

  // fresh random registers, pc and flags
  function automatic cpu_state_t random_state();
    cpu_state_t s;
    for (int i = 0; i < NUM_REGS; i++)
      s.regs[i] = word_t'($urandom());
    s.pc    = word_t'($urandom());
    s.flags = FLAG_W'($urandom());
    return s;
  endfunction

  function automatic word_t random_instr();
    word_t w;
    w = word_t'($urandom());
    if (w == HALT_CODE)
      w = 16'h0001;                                 // keep it off the halt code
    return w;
  endfunction

  // one clock of stimulus, halts stop once the last dump is under way
  task automatic drive_cycle(input logic want_halt);
    @(posedge clk_);
    #DRIVE_DELAY;
    if (want_halt && (dumps_started < NUM_DUMPS || dump_busy))
      instr = HALT_CODE;
    else
      instr = random_instr();
    cpu_state = random_state();                     // state keeps moving mid-dump
  endtask

  initial
  begin
    int unsigned gap_len;
    int unsigned halt_len;
    void'($urandom(32'h9ada));
    clk_      = 1'b0;
    rst       = 1'b0;
    instr     = 16'h1234;
    cpu_state = '0;
    repeat (5) @(posedge clk_);
    #DRIVE_DELAY;
    rst = 1'b1;
    repeat (30) drive_cycle(1'b0);                  // quiet line before any halt
    while (dumps_done < NUM_DUMPS)
    begin
      gap_len  = 1 + ($urandom() % 12);
      halt_len = ($urandom() % 8 == 0) ? 60 + ($urandom() % 80) : 1 + ($urandom() % 12);
      repeat (gap_len) drive_cycle(1'b0);
      repeat (halt_len) drive_cycle(1'b1);          // long runs are held halts
    end
    repeat (20) drive_cycle(1'b0);
    $display("run done: %0d dumps, %0d value errors, %0d protocol errors",
             dumps_done, value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0 && dumps_done == NUM_DUMPS)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  // worst case is every dump at full uart time plus slack
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_);
    $display("watchdog expired after %0d cycles with %0d of %0d dumps finished",
             WATCHDOG_CYCLES, dumps_done, NUM_DUMPS);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- vis_dump.f
source/vis_pkg.sv
source/halt_snapshot.sv
source/dump_formatter.sv
source/byte_fifo.sv
source/uart_tx.sv
source/vis_dev.sv
test/vis_monitor.sv
test/tb_vis_dev.sv

//--- run_sim.sh
#!/bin/sh
# compile with verilator, run, then look for the fail banner in the log
cd "$(dirname "$0")" &&
verilator --binary --timing -f vis_dump.f --top-module tb_vis_dev -o tb_vis_dev > build.log 2>&1 &&
./obj_dir/tb_vis_dev > sim.log 2>&1 || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "no verdict in sim.log"; exit 1; }
echo "simulation passed"
